// File: nic_pkg.sv
package nic_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int BE_W = DATA_W / 8;
	localparam int PCI_ADDR_W = 32;
	localparam int NUM_BARS = 8;

	// Interrupt causes
	localparam int NUM_CAUSES = 3;
	localparam int CAUSE_LSC = 2;
	localparam int CAUSE_SDP6 = 13;
	localparam int CAUSE_SDP7 = 14;

	// Bit order of the cause pulses from the event block
	localparam int CI_LSC = 0;
	localparam int CI_SDP6 = 1;
	localparam int CI_SDP7 = 2;

	// Register byte offsets
	localparam int OFS_CTRL = 'h00;
	localparam int OFS_STATUS = 'h08;
	localparam int OFS_SCRATCH = 'h0C;
	localparam int OFS_ICR = 'hC0;
	localparam int OFS_IMS = 'hD0;
	localparam int OFS_IMC = 'hD8;

	localparam int CTRL_RST_BIT = 26;

	// STATUS layout
	localparam int STATUS_FD_BIT = 0;
	localparam int STATUS_LU_BIT = 1;
	localparam int STATUS_SPD_LSB = 6;

endpackage

// File: reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if import nic_pkg::*; #(
	parameter int REG_ADDR_W = 8
) ();

	logic wr_stb;
	logic rd_stb;
	logic [REG_ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [BE_W-1:0] be;
	logic [DATA_W-1:0] rdata;
	logic rd_vld;
	logic rd_err;

	modport master(output wr_stb, rd_stb, addr, wdata, be, input rdata, rd_vld, rd_err);
	modport slave(input wr_stb, rd_stb, addr, wdata, be, output rdata, rd_vld, rd_err);

endinterface

// File: rst_seq.sv
`timescale 1ns/1ps

module rst_seq #(
	parameter int RST_CYCLES = 16
) (
	input logic CLK,
	input logic RST,
	input logic rst_request_i,
	output logic core_rst_o
);

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;
	logic core_rst_q;

	// Restart the count on power-on or software reset
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cnt_q <= '0;
			core_rst_q <= 1'b1;
		end else if (rst_request_i) begin
			cnt_q <= '0;
			core_rst_q <= 1'b1;
		end else if (core_rst_q) begin
			cnt_q <= cnt_q + 1'b1;
			if (cnt_q == CNT_W'(RST_CYCLES - 1))
				core_rst_q <= 1'b0;
		end
	end

	assign core_rst_o = core_rst_q;

endmodule

// File: pci_target.sv
`timescale 1ns/1ps

module pci_target import nic_pkg::*; #(
	parameter int REG_ADDR_W = 8
) (
	input logic CLK,
	input logic RST,
	input logic [PCI_ADDR_W-1:0] addr_i,
	input logic addr_vld_i,
	input logic [NUM_BARS-1:0] base_hit_i,
	input logic [DATA_W-1:0] adio_out_i,
	output logic [DATA_W-1:0] adio_in_o,
	input logic s_wrdn_i,
	input logic s_data_i,
	input logic s_data_vld_i,
	input logic [BE_W-1:0] s_cbe_i,
	output logic s_ready_o,
	output logic s_term_o,
	output logic s_abort_o,
	reg_bus_if.master bus_o
);

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_WR_WAIT = 3'd1;
	localparam logic [2:0] ST_RD_WAIT = 3'd2;
	localparam logic [2:0] ST_RD_DONE = 3'd3;
	localparam logic [2:0] ST_HOLD = 3'd4;

	logic [2:0] state;
	logic hit;
	logic wr_dir_q;
	logic err_q;
	logic wr_stb_q;
	logic rd_stb_q;
	logic [REG_ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [BE_W-1:0] be_q;
	logic [DATA_W-1:0] rdata_q;

	// Only base register 0 maps the controller
	assign hit = addr_vld_i && base_hit_i[0];

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= ST_IDLE;
			wr_dir_q <= 1'b0;
			err_q <= 1'b0;
			wr_stb_q <= 1'b0;
			rd_stb_q <= 1'b0;
		end else begin
			wr_stb_q <= 1'b0;
			rd_stb_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (hit) begin
						wr_dir_q <= s_wrdn_i;
						err_q <= 1'b0;
						rd_stb_q <= !s_wrdn_i;
						state <= s_wrdn_i ? ST_WR_WAIT : ST_RD_WAIT;
					end
				end
				ST_WR_WAIT: begin
					if (s_data_vld_i) begin
						wr_stb_q <= 1'b1;
						state <= ST_HOLD;
					end
				end
				ST_RD_WAIT: state <= ST_RD_DONE;
				ST_RD_DONE: begin
					if (bus_o.rd_vld) begin
						err_q <= bus_o.rd_err;
						state <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					if (!s_data_i)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == ST_IDLE && hit)
			addr_q <= addr_i[REG_ADDR_W-1:0];
		if (state == ST_WR_WAIT && s_data_vld_i) begin
			wdata_q <= adio_out_i;
			be_q <= ~s_cbe_i;
		end
		if (state == ST_RD_DONE && bus_o.rd_vld)
			rdata_q <= bus_o.rdata;
	end

	// Read data passes straight through in the answer cycle
	always_comb begin
		s_ready_o = 1'b0;
		s_term_o = 1'b0;
		s_abort_o = 1'b0;
		adio_in_o = '0;
		case (state)
			ST_WR_WAIT: begin
				s_ready_o = 1'b1;
				s_term_o = 1'b1;
			end
			ST_RD_DONE: begin
				adio_in_o = bus_o.rdata;
				s_ready_o = bus_o.rd_vld && !bus_o.rd_err;
				s_term_o = bus_o.rd_vld && !bus_o.rd_err;
				s_abort_o = bus_o.rd_vld && bus_o.rd_err;
			end
			ST_HOLD: begin
				if (!wr_dir_q)
					adio_in_o = rdata_q;
				s_ready_o = s_data_i && !err_q;
				s_term_o = s_data_i && !err_q;
				s_abort_o = s_data_i && err_q;
			end
			default: adio_in_o = '0;
		endcase
	end

	assign bus_o.wr_stb = wr_stb_q;
	assign bus_o.rd_stb = rd_stb_q;
	assign bus_o.addr = addr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.be = be_q;

endmodule

// File: nic_events.sv
`timescale 1ns/1ps

module nic_events import nic_pkg::*; (
	input logic CLK,
	input logic core_rst_i,
	input logic phy_lsc_i,
	input logic sdp6_data_i,
	input logic sdp7_data_i,
	output logic [NUM_CAUSES-1:0] cause_o
);

	logic [NUM_CAUSES-1:0] raw;
	logic [NUM_CAUSES-1:0] sync1_q;
	logic [NUM_CAUSES-1:0] sync2_q;
	logic [NUM_CAUSES-1:0] prev_q;
	logic [NUM_CAUSES-1:0] pulse_q;

	assign raw[CI_LSC] = phy_lsc_i;
	assign raw[CI_SDP6] = sdp6_data_i;
	assign raw[CI_SDP7] = sdp7_data_i;

	always_ff @(posedge CLK or posedge core_rst_i) begin
		if (core_rst_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q <= '0;
			pulse_q <= '0;
		end else begin
			sync1_q <= raw;
			sync2_q <= sync1_q;
			prev_q <= sync2_q;
			// Rising edges only
			pulse_q <= sync2_q & ~prev_q;
		end
	end

	assign cause_o = pulse_q;

endmodule

// File: nic_regs.sv
`timescale 1ns/1ps

module nic_regs import nic_pkg::*; #(
	parameter int REG_ADDR_W = 8
) (
	input logic CLK,
	input logic core_rst_i,
	reg_bus_if.slave bus_i,
	input logic [NUM_CAUSES-1:0] cause_i,
	input logic [1:0] phy_speed_i,
	input logic phy_duplex_i,
	input logic phy_up_i,
	output logic int_n_o,
	output logic rst_request_o
);

	localparam logic [DATA_W-1:0] CTRL_WR_MASK = ~(DATA_W'(1) << CTRL_RST_BIT);

	logic [DATA_W-1:0] ctrl_q;
	logic [DATA_W-1:0] scratch_q;
	logic [NUM_CAUSES-1:0] icr_q;
	logic [NUM_CAUSES-1:0] ims_q;
	logic int_n_q;
	logic rst_req_q;
	logic [DATA_W-1:0] status_w;
	logic [DATA_W-1:0] wmask;
	logic [DATA_W-1:0] wr_val;
	logic [DATA_W-1:0] rd_word;
	logic map_hit;
	logic wr_ctrl;
	logic wr_scratch;
	logic wr_ims;
	logic wr_imc;
	logic rd_icr;
	logic rd_vld_q;
	logic rd_err_q;
	logic [DATA_W-1:0] rdata_q;

	function automatic logic [DATA_W-1:0] spread(input logic [NUM_CAUSES-1:0] bits);
		logic [DATA_W-1:0] word;
		word = '0;
		word[CAUSE_LSC] = bits[CI_LSC];
		word[CAUSE_SDP6] = bits[CI_SDP6];
		word[CAUSE_SDP7] = bits[CI_SDP7];
		return word;
	endfunction

	function automatic logic [NUM_CAUSES-1:0] gather(input logic [DATA_W-1:0] word);
		logic [NUM_CAUSES-1:0] bits;
		bits[CI_LSC] = word[CAUSE_LSC];
		bits[CI_SDP6] = word[CAUSE_SDP6];
		bits[CI_SDP7] = word[CAUSE_SDP7];
		return bits;
	endfunction

	always_comb begin
		for (int i = 0; i < BE_W; i++) begin
			wmask[8*i +: 8] = {8{bus_i.be[i]}};
		end
	end

	assign wr_val = bus_i.wdata & wmask;

	always_comb begin
		status_w = '0;
		status_w[STATUS_FD_BIT] = phy_duplex_i;
		status_w[STATUS_LU_BIT] = phy_up_i;
		status_w[STATUS_SPD_LSB +: 2] = phy_speed_i;
	end

	assign wr_ctrl = bus_i.wr_stb && (bus_i.addr == REG_ADDR_W'(OFS_CTRL));
	assign wr_scratch = bus_i.wr_stb && (bus_i.addr == REG_ADDR_W'(OFS_SCRATCH));
	assign wr_ims = bus_i.wr_stb && (bus_i.addr == REG_ADDR_W'(OFS_IMS));
	assign wr_imc = bus_i.wr_stb && (bus_i.addr == REG_ADDR_W'(OFS_IMC));
	assign rd_icr = bus_i.rd_stb && (bus_i.addr == REG_ADDR_W'(OFS_ICR));

	// Read decode with IMC reading as zero
	always_comb begin
		map_hit = 1'b1;
		rd_word = '0;
		case (bus_i.addr)
			REG_ADDR_W'(OFS_CTRL): rd_word = ctrl_q;
			REG_ADDR_W'(OFS_STATUS): rd_word = status_w;
			REG_ADDR_W'(OFS_SCRATCH): rd_word = scratch_q;
			REG_ADDR_W'(OFS_ICR): rd_word = spread(icr_q);
			REG_ADDR_W'(OFS_IMS): rd_word = spread(ims_q);
			REG_ADDR_W'(OFS_IMC): rd_word = '0;
			default: map_hit = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or posedge core_rst_i) begin
		if (core_rst_i) begin
			ctrl_q <= '0;
			scratch_q <= '0;
			icr_q <= '0;
			ims_q <= '0;
			int_n_q <= 1'b1;
			rst_req_q <= 1'b0;
		end else begin
			// Reset bit only pulses the request and is never stored
			rst_req_q <= wr_ctrl && wr_val[CTRL_RST_BIT];
			if (wr_ctrl)
				ctrl_q <= (ctrl_q & ~wmask) | (wr_val & CTRL_WR_MASK);
			if (wr_scratch)
				scratch_q <= (scratch_q & ~wmask) | wr_val;
			if (wr_ims)
				ims_q <= ims_q | gather(wr_val);
			else if (wr_imc)
				ims_q <= ims_q & ~gather(wr_val);
			// New causes win over clear-on-read
			icr_q <= (rd_icr ? '0 : icr_q) | cause_i;
			int_n_q <= !(|(icr_q & ims_q));
		end
	end

	// Read response stays live during core reset
	always_ff @(posedge CLK) begin
		rd_vld_q <= bus_i.rd_stb;
		rd_err_q <= bus_i.rd_stb && !map_hit;
		if (bus_i.rd_stb)
			rdata_q <= rd_word;
	end

	assign bus_i.rd_vld = rd_vld_q;
	assign bus_i.rd_err = rd_err_q;
	assign bus_i.rdata = rdata_q;
	assign int_n_o = int_n_q;
	assign rst_request_o = rst_req_q;

endmodule

// File: nic_bridge.sv
`timescale 1ns/1ps

module nic_bridge import nic_pkg::*; #(
	parameter int REG_ADDR_W = 8,
	parameter int RST_CYCLES = 16
) (
	input logic CLK,
	input logic RST,
	// Address phase
	input logic [PCI_ADDR_W-1:0] addr_i,
	input logic addr_vld_i,
	input logic [NUM_BARS-1:0] base_hit_i,
	// Data
	input logic [DATA_W-1:0] adio_out_i,
	output logic [DATA_W-1:0] adio_in_o,
	// Data phase
	input logic s_wrdn_i,
	input logic s_data_i,
	input logic s_data_vld_i,
	input logic [BE_W-1:0] s_cbe_i,
	// Target termination
	output logic s_ready_o,
	output logic s_term_o,
	output logic s_abort_o,
	output logic int_n_o,
	// PHY and GPI
	input logic [1:0] phy_speed_i,
	input logic phy_duplex_i,
	input logic phy_up_i,
	input logic phy_lsc_i,
	input logic sdp6_data_i,
	input logic sdp7_data_i,
	output logic phy_reset_out_o
);

	logic rst_request;
	logic core_rst;
	logic [NUM_CAUSES-1:0] cause;

	reg_bus_if #(.REG_ADDR_W(REG_ADDR_W)) u_bus ();

	rst_seq #(.RST_CYCLES(RST_CYCLES)) u_rst_seq (
		.CLK(CLK),
		.RST(RST),
		.rst_request_i(rst_request),
		.core_rst_o(core_rst)
	);

	pci_target #(.REG_ADDR_W(REG_ADDR_W)) u_pci_target (
		.CLK(CLK),
		.RST(RST),
		.addr_i(addr_i),
		.addr_vld_i(addr_vld_i),
		.base_hit_i(base_hit_i),
		.adio_out_i(adio_out_i),
		.adio_in_o(adio_in_o),
		.s_wrdn_i(s_wrdn_i),
		.s_data_i(s_data_i),
		.s_data_vld_i(s_data_vld_i),
		.s_cbe_i(s_cbe_i),
		.s_ready_o(s_ready_o),
		.s_term_o(s_term_o),
		.s_abort_o(s_abort_o),
		.bus_o(u_bus.master)
	);

	nic_events u_nic_events (
		.CLK(CLK),
		.core_rst_i(core_rst),
		.phy_lsc_i(phy_lsc_i),
		.sdp6_data_i(sdp6_data_i),
		.sdp7_data_i(sdp7_data_i),
		.cause_o(cause)
	);

	nic_regs #(.REG_ADDR_W(REG_ADDR_W)) u_nic_regs (
		.CLK(CLK),
		.core_rst_i(core_rst),
		.bus_i(u_bus.slave),
		.cause_i(cause),
		.phy_speed_i(phy_speed_i),
		.phy_duplex_i(phy_duplex_i),
		.phy_up_i(phy_up_i),
		.int_n_o(int_n_o),
		.rst_request_o(rst_request)
	);

	assign phy_reset_out_o = core_rst;

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input logic [31:0] adio_in_i,
	input logic s_ready_i,
	input logic s_term_i,
	input logic s_abort_i,
	input logic int_n_i,
	input logic phy_reset_i
);

	int err_count = 0;
	int test_count = 0;
	int test_fail = 0;
	int test_err_start = 0;

	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
			err_count++;
		end
	endtask

	// Normal termination and target abort are exclusive
	task automatic check_term(input logic exp_abort);
		compare_flag("s_ready_o", s_ready_i, !exp_abort);
		compare_flag("s_term_o", s_term_i, !exp_abort);
		compare_flag("s_abort_o", s_abort_i, exp_abort);
	endtask

	task automatic check_read(input logic [31:0] exp, input logic exp_abort);
		check_term(exp_abort);
		if (!exp_abort)
			compare_word("adio_in_o", adio_in_i, exp);
	endtask

	task automatic check_int(input logic exp);
		compare_flag("int_n_o", int_n_i, exp);
	endtask

	task automatic check_phy_reset(input logic exp);
		compare_flag("phy_reset_out_o", phy_reset_i, exp);
	endtask

	task automatic check_idle();
		compare_flag("s_ready_o", s_ready_i, 1'b0);
		compare_flag("s_term_o", s_term_i, 1'b0);
		compare_flag("s_abort_o", s_abort_i, 1'b0);
		check_int(1'b1);
		check_phy_reset(1'b1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		err_count++;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count != test_err_start) begin
			test_fail++;
			$display("test %s: %0d errors", name, err_count - test_err_start);
		end else begin
			$display("test %s: ok", name);
		end
		test_err_start = err_count;
	endtask

	task automatic print_counts();
		$display("summary: %0d tests, %0d failed, %0d errors", test_count, test_fail,
			err_count);
	endtask

endmodule

// File: tb_nic_bridge.sv
`timescale 1ns/1ps

module tb_nic_bridge;

	localparam int TIMEOUT = 50;
	localparam logic [7:0] CTRL_OFS = 8'h00;
	localparam logic [7:0] STATUS_OFS = 8'h08;
	localparam logic [7:0] SCRATCH_OFS = 8'h0C;
	localparam logic [7:0] ICR_OFS = 8'hC0;
	localparam logic [7:0] IMS_OFS = 8'hD0;
	localparam logic [7:0] IMC_OFS = 8'hD8;
	localparam logic [31:0] RESET_REQ = 32'h0400_0000;

	logic CLK;
	logic RST;
	logic [31:0] addr_i;
	logic addr_vld_i;
	logic [7:0] base_hit_i;
	logic [31:0] adio_out_i;
	logic [31:0] adio_in_o;
	logic s_wrdn_i;
	logic s_data_i;
	logic s_data_vld_i;
	logic [3:0] s_cbe_i;
	logic s_ready_o;
	logic s_term_o;
	logic s_abort_o;
	logic int_n_o;
	logic [1:0] phy_speed_i;
	logic phy_duplex_i;
	logic phy_up_i;
	logic phy_lsc_i;
	logic sdp6_data_i;
	logic sdp7_data_i;
	logic phy_reset_out_o;

	integer seed;
	logic [31:0] scratch_model;
	logic [2:0] mask_model;
	logic [2:0] icr_model;

	nic_bridge #(.REG_ADDR_W(8), .RST_CYCLES(16)) u_nic_bridge (
		.CLK(CLK), .RST(RST),
		.addr_i(addr_i), .addr_vld_i(addr_vld_i), .base_hit_i(base_hit_i),
		.adio_out_i(adio_out_i), .adio_in_o(adio_in_o),
		.s_wrdn_i(s_wrdn_i), .s_data_i(s_data_i), .s_data_vld_i(s_data_vld_i),
		.s_cbe_i(s_cbe_i),
		.s_ready_o(s_ready_o), .s_term_o(s_term_o), .s_abort_o(s_abort_o),
		.int_n_o(int_n_o),
		.phy_speed_i(phy_speed_i), .phy_duplex_i(phy_duplex_i), .phy_up_i(phy_up_i),
		.phy_lsc_i(phy_lsc_i), .sdp6_data_i(sdp6_data_i), .sdp7_data_i(sdp7_data_i),
		.phy_reset_out_o(phy_reset_out_o)
	);

	tb_checker u_checker (
		.adio_in_i(adio_in_o), .s_ready_i(s_ready_o), .s_term_i(s_term_o),
		.s_abort_i(s_abort_o), .int_n_i(int_n_o), .phy_reset_i(phy_reset_out_o)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Cause bits 2, 13 and 14 of the cause word
	function automatic logic [31:0] cause_word(input logic [2:0] bits);
		return {17'h0, bits[2], bits[1], 10'h0, bits[0], 2'h0};
	endfunction

	function automatic logic [2:0] cause_bits(input logic [31:0] word);
		return {word[14], word[13], word[2]};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] be);
		logic [31:0] res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic is_mapped(input logic [7:0] ofs);
		return ofs == CTRL_OFS || ofs == STATUS_OFS || ofs == SCRATCH_OFS ||
			ofs == ICR_OFS || ofs == IMS_OFS || ofs == IMC_OFS;
	endfunction

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic address_phase(input logic [7:0] ofs, input logic wr);
		addr_i = {24'h0, ofs};
		addr_vld_i = 1'b1;
		base_hit_i = 8'h01;
		s_wrdn_i = wr;
		s_data_i = 1'b1;
		step();
		addr_vld_i = 1'b0;
		base_hit_i = 8'h00;
	endtask

	task automatic wait_termination(output logic seen);
		int n;
		n = 0;
		while (!(s_ready_o || s_abort_o) && n < TIMEOUT) begin
			step();
			n++;
		end
		seen = s_ready_o || s_abort_o;
	endtask

	task automatic bus_write(input logic [7:0] ofs, input logic [31:0] data,
			input logic [3:0] be);
		logic seen;
		address_phase(ofs, 1'b1);
		wait_termination(seen);
		if (!seen)
			u_checker.report_timeout($sformatf("write to %h got no termination", ofs));
		else
			u_checker.check_term(1'b0);
		adio_out_i = data;
		s_cbe_i = ~be;
		s_data_vld_i = 1'b1;
		step();
		// Termination stays up while s_data_i is high
		if (seen)
			u_checker.check_term(1'b0);
		s_data_vld_i = 1'b0;
		s_data_i = 1'b0;
		s_cbe_i = 4'hF;
		step();
	endtask

	task automatic bus_read(input logic [7:0] ofs, input logic [31:0] exp,
			input logic exp_abort);
		logic seen;
		address_phase(ofs, 1'b0);
		wait_termination(seen);
		if (!seen) begin
			u_checker.report_timeout($sformatf("read from %h got no termination", ofs));
		end else begin
			u_checker.check_read(exp, exp_abort);
			// Data and termination are held while s_data_i stays high
			step();
			u_checker.check_read(exp, exp_abort);
		end
		s_data_i = 1'b0;
		step();
		step();
	endtask

	task automatic wait_phy_reset(input logic exp);
		int n;
		n = 0;
		while (phy_reset_out_o !== exp && n < TIMEOUT) begin
			step();
			n++;
		end
		if (phy_reset_out_o !== exp)
			u_checker.report_timeout("phy_reset_out_o never reached the expected level");
	endtask

	task automatic wait_int_level(input logic exp);
		int n;
		n = 0;
		while (int_n_o !== exp && n < TIMEOUT) begin
			step();
			n++;
		end
		if (int_n_o !== exp)
			u_checker.report_timeout("int_n_o never reached the expected level");
	endtask

	task automatic hold_int_high(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			step();
			u_checker.check_int(1'b1);
		end
	endtask

	task automatic run_scratch_test();
		logic [31:0] data;
		logic [3:0] be;
		for (int i = 0; i < 8; i++) begin
			data = $random(seed);
			be = 4'($random(seed));
			bus_write(SCRATCH_OFS, data, be);
			scratch_model = merge_bytes(scratch_model, data, be);
			bus_read(SCRATCH_OFS, scratch_model, 1'b0);
		end
		u_checker.finish_test("scratch");
	endtask

	task automatic run_status_test();
		logic [31:0] data;
		for (int i = 0; i < 4; i++) begin
			phy_speed_i = 2'($random(seed));
			phy_duplex_i = 1'($random(seed));
			phy_up_i = 1'($random(seed));
			bus_read(STATUS_OFS, {24'h0, phy_speed_i, 4'h0, phy_up_i, phy_duplex_i}, 1'b0);
		end
		// Reset bit kept clear so the core is not reset
		for (int i = 0; i < 4; i++) begin
			data = $random(seed) & ~RESET_REQ;
			bus_write(CTRL_OFS, data, 4'hF);
			bus_read(CTRL_OFS, data, 1'b0);
		end
		u_checker.finish_test("status");
	endtask

	task automatic run_unmapped_test();
		logic [7:0] ofs;
		for (int i = 0; i < 4; i++) begin
			ofs = 8'($random(seed));
			while (is_mapped(ofs))
				ofs = ofs + 8'd1;
			bus_read(ofs, 32'h0, 1'b1);
		end
		u_checker.finish_test("unmapped");
	endtask

	task automatic run_irq_test();
		logic [31:0] ims_word;
		logic [31:0] imc_word;
		logic [2:0] raise;
		for (int i = 0; i < 6; i++) begin
			ims_word = $random(seed);
			imc_word = $random(seed);
			bus_write(IMS_OFS, ims_word, 4'hF);
			mask_model = mask_model | cause_bits(ims_word);
			bus_write(IMC_OFS, imc_word, 4'hF);
			mask_model = mask_model & ~cause_bits(imc_word);
			raise = 3'($random(seed));
			phy_lsc_i = raise[0];
			sdp6_data_i = raise[1];
			sdp7_data_i = raise[2];
			icr_model = icr_model | raise;
			step();
			if (|(icr_model & mask_model))
				wait_int_level(1'b0);
			else
				hold_int_high(10);
			phy_lsc_i = 1'b0;
			sdp6_data_i = 1'b0;
			sdp7_data_i = 1'b0;
			bus_read(ICR_OFS, cause_word(icr_model), 1'b0);
			icr_model = 3'b000;
			bus_read(ICR_OFS, 32'h0, 1'b0);
			wait_int_level(1'b1);
		end
		u_checker.finish_test("interrupt");
	endtask

	task automatic run_reset_test();
		bus_write(SCRATCH_OFS, $random(seed) | 32'h1, 4'hF);
		bus_write(IMS_OFS, cause_word(3'b111), 4'hF);
		bus_write(CTRL_OFS, RESET_REQ | 32'h0000_00FF, 4'hF);
		wait_phy_reset(1'b1);
		wait_phy_reset(1'b0);
		scratch_model = 32'h0;
		mask_model = 3'b000;
		bus_read(SCRATCH_OFS, 32'h0, 1'b0);
		bus_read(IMS_OFS, 32'h0, 1'b0);
		bus_read(CTRL_OFS, 32'h0, 1'b0);
		u_checker.finish_test("soft_reset");
	endtask

	initial begin
		seed = 26;
		RST = 1'b1;
		addr_i = 32'h0;
		addr_vld_i = 1'b0;
		base_hit_i = 8'h00;
		adio_out_i = 32'h0;
		s_wrdn_i = 1'b0;
		s_data_i = 1'b0;
		s_data_vld_i = 1'b0;
		s_cbe_i = 4'hF;
		phy_speed_i = 2'b00;
		phy_duplex_i = 1'b0;
		phy_up_i = 1'b0;
		phy_lsc_i = 1'b0;
		sdp6_data_i = 1'b0;
		sdp7_data_i = 1'b0;
		scratch_model = 32'h0;
		mask_model = 3'b000;
		icr_model = 3'b000;
		repeat (2) @(posedge CLK);
		#1;
		RST = 1'b0;
		u_checker.check_idle();
		wait_phy_reset(1'b0);
		u_checker.finish_test("power_on");
		run_scratch_test();
		run_status_test();
		run_unmapped_test();
		run_irq_test();
		run_reset_test();
		u_checker.print_counts();
		if (u_checker.err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: nic_bridge.f
nic_pkg.sv
reg_bus_if.sv
rst_seq.sv
pci_target.sv
nic_events.sv
nic_regs.sv
nic_bridge.sv
tb_checker.sv
tb_nic_bridge.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing
TOP = tb_nic_bridge
FILELIST = nic_bridge.f
OBJ_DIR = obj_dir
LOG = sim.log

SIM = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
